/* logic/mipsPkg.sv */
package mipsPkg;

    parameter int instructionWidth = 32;
    parameter int wordAddressWidth = 30;    // memories are addressed by word

    typedef logic [instructionWidth-1:0] wordType;
    typedef logic [4:0] regIndexType;
    typedef logic [5:0] opcodeType;
    typedef logic [5:0] functType;

    parameter regIndexType linkRegister = 5'd31;    // JAL target register

    // primary opcodes
    parameter opcodeType opSpecial = 6'h00;
    parameter opcodeType opJ = 6'h02;
    parameter opcodeType opJal = 6'h03;
    parameter opcodeType opBeq = 6'h04;
    parameter opcodeType opBne = 6'h05;
    parameter opcodeType opAddiu = 6'h09;
    parameter opcodeType opSlti = 6'h0a;
    parameter opcodeType opAndi = 6'h0c;
    parameter opcodeType opOri = 6'h0d;
    parameter opcodeType opXori = 6'h0e;
    parameter opcodeType opLui = 6'h0f;
    parameter opcodeType opLw = 6'h23;
    parameter opcodeType opSw = 6'h2b;

    // funct field of SPECIAL
    parameter functType functSll = 6'h00;
    parameter functType functSrl = 6'h02;
    parameter functType functJr = 6'h08;
    parameter functType functAddu = 6'h21;
    parameter functType functSubu = 6'h23;
    parameter functType functAnd = 6'h24;
    parameter functType functOr = 6'h25;
    parameter functType functXor = 6'h26;
    parameter functType functNor = 6'h27;
    parameter functType functSlt = 6'h2a;
    parameter functType functSltu = 6'h2b;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu, aluSll, aluSrl, aluLui
    } aluOpType;

    typedef enum logic [1:0] {fwdRegister, fwdMem, fwdWb} forwardSelectType;

endpackage

/* logic/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage import mipsPkg::*; #(
    parameter wordType resetVector = '0
) (
    input  logic clock,
    input  logic reset,
    input  logic stall,
    input  logic [1:0] pcSelect,
    input  wordType jumpTarget,
    input  wordType branchTarget,
    input  wordType registerTarget,
    input  logic [instructionWidth-1:0] instMemIn,
    output logic [wordAddressWidth-1:0] instMemAddress,
    output logic instMemRead,
    output logic [instructionWidth-1:0] ifidInstruction,
    output wordType ifidPcPlus4
);
    wordType pc;
    wordType pcPlus4;
    wordType nextPc;

    assign pcPlus4 = pc + 32'd4;
    assign instMemAddress = pc[31:2];
    assign instMemRead = !stall;

    always_comb begin
        case (pcSelect)
            2'd1: nextPc = jumpTarget;
            2'd2: nextPc = branchTarget;      // taken BEQ/BNE
            2'd3: nextPc = registerTarget;    // JR
            default: nextPc = pcPlus4;
        endcase
    end

    // the word behind a branch is its delay slot, so IF/ID is never flushed
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= resetVector;
            ifidInstruction <= '0;    // all zeros decodes as a NOP
        end else if (!stall) begin
            pc <= nextPc;
            ifidInstruction <= instMemIn;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) ifidPcPlus4 <= pcPlus4;
    end

endmodule

/* logic/registerFile.sv */
`timescale 1ns/1ps

module registerFile import mipsPkg::*; (
    input  logic clock,
    input  logic reset,
    input  regIndexType readIndexA,
    input  regIndexType readIndexB,
    input  regIndexType writeIndex,
    input  logic writeEnable,
    input  wordType writeData,
    output wordType readDataA,
    output wordType readDataB
);
    wordType registers [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (writeEnable && writeIndex != '0) begin
            registers[writeIndex] <= writeData;
        end
    end

    // same-cycle write is not bypassed here, WB forwarding covers it
    assign readDataA = (readIndexA == '0) ? '0 : registers[readIndexA];
    assign readDataB = (readIndexB == '0) ? '0 : registers[readIndexB];

endmodule

/* logic/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import mipsPkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic stall,
    input  logic [instructionWidth-1:0] instruction,
    input  wordType pcPlus4,
    input  wordType readDataA,
    input  wordType readDataB,
    input  wordType memAluResult,
    input  wordType wbWriteData,
    input  forwardSelectType rsForward,
    input  forwardSelectType rtForward,
    output regIndexType readIndexA,
    output regIndexType readIndexB,
    output logic usesRs,
    output logic usesRt,
    output logic isBranch,
    output logic [1:0] pcSelect,
    output wordType jumpTarget,
    output wordType branchTarget,
    output wordType registerTarget,
    output aluOpType exAluOp,
    output logic exAluSrcImm,
    output logic exRegWrite,
    output logic exMemRead,
    output logic exMemWrite,
    output logic exLink,
    output regIndexType exDest,
    output regIndexType exRs,
    output regIndexType exRt,
    output wordType exOperandA,
    output wordType exOperandB,
    output wordType exImmediate,
    output logic [4:0] exShamt,
    output wordType exPcPlus8
);
    opcodeType opcode;
    functType funct;
    logic [15:0] imm16;
    wordType operandA;
    wordType operandB;
    aluOpType aluOp;
    logic aluSrcImm;
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic link;
    logic zeroExtend;
    regIndexType dest;

    assign opcode = instruction[31:26];
    assign funct = instruction[5:0];
    assign imm16 = instruction[15:0];
    assign readIndexA = instruction[25:21];
    assign readIndexB = instruction[20:16];

    assign operandA = (rsForward == fwdMem) ? memAluResult :
                      (rsForward == fwdWb) ? wbWriteData : readDataA;
    assign operandB = (rtForward == fwdMem) ? memAluResult :
                      (rtForward == fwdWb) ? wbWriteData : readDataB;

    assign jumpTarget = {pcPlus4[31:28], instruction[25:0], 2'b00};
    assign branchTarget = pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};
    assign registerTarget = operandA;

    // source usage for the hazard checks
    assign usesRs = !(opcode == opJ || opcode == opJal || opcode == opLui);
    assign usesRt = (opcode == opSpecial) || (opcode == opBeq) || (opcode == opBne) ||
                    (opcode == opSw);
    assign isBranch = (opcode == opBeq) || (opcode == opBne) ||
                      (opcode == opSpecial && funct == functJr);

    always_comb begin
        aluOp = aluAdd;
        aluSrcImm = 1'b1;
        regWrite = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        link = 1'b0;
        zeroExtend = 1'b0;
        dest = readIndexB;    // immediates write rt
        pcSelect = 2'd0;
        case (opcode)
            opSpecial: begin
                aluSrcImm = 1'b0;
                regWrite = 1'b1;
                dest = instruction[15:11];
                case (funct)
                    functAddu: aluOp = aluAdd;
                    functSubu: aluOp = aluSub;
                    functAnd: aluOp = aluAnd;
                    functOr: aluOp = aluOr;
                    functXor: aluOp = aluXor;
                    functNor: aluOp = aluNor;
                    functSlt: aluOp = aluSlt;
                    functSltu: aluOp = aluSltu;
                    functSll: aluOp = aluSll;
                    functSrl: aluOp = aluSrl;
                    functJr: begin
                        regWrite = 1'b0;
                        pcSelect = 2'd3;
                    end
                    default: regWrite = 1'b0;
                endcase
            end
            opJ: pcSelect = 2'd1;
            opJal: begin
                pcSelect = 2'd1;
                link = 1'b1;
                regWrite = 1'b1;
                dest = linkRegister;
            end
            opBeq: if (operandA == operandB) pcSelect = 2'd2;
            opBne: if (operandA != operandB) pcSelect = 2'd2;
            opAddiu: regWrite = 1'b1;
            opSlti: begin
                aluOp = aluSlt;
                regWrite = 1'b1;
            end
            opAndi: begin
                aluOp = aluAnd;
                zeroExtend = 1'b1;
                regWrite = 1'b1;
            end
            opOri: begin
                aluOp = aluOr;
                zeroExtend = 1'b1;
                regWrite = 1'b1;
            end
            opXori: begin
                aluOp = aluXor;
                zeroExtend = 1'b1;
                regWrite = 1'b1;
            end
            opLui: begin
                aluOp = aluLui;
                regWrite = 1'b1;
            end
            opLw: begin
                memRead = 1'b1;
                regWrite = 1'b1;
            end
            opSw: memWrite = 1'b1;
            default: regWrite = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset || stall) begin    // bubble
            exRegWrite <= 1'b0;
            exMemRead <= 1'b0;
            exMemWrite <= 1'b0;
        end else begin
            exRegWrite <= regWrite;
            exMemRead <= memRead;
            exMemWrite <= memWrite;
        end
    end

    always_ff @(posedge clock) begin
        exAluOp <= aluOp;
        exAluSrcImm <= aluSrcImm;
        exLink <= link;
        exDest <= dest;
        exRs <= readIndexA;
        exRt <= readIndexB;
        exOperandA <= operandA;
        exOperandB <= operandB;
        exImmediate <= zeroExtend ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
        exShamt <= instruction[10:6];
        exPcPlus8 <= pcPlus4 + 32'd4;    // return address past the delay slot
    end

endmodule

/* logic/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*; (
    input  regIndexType idRs,
    input  regIndexType idRt,
    input  logic idUsesRs,
    input  logic idUsesRt,
    input  logic idIsBranch,
    input  regIndexType exRs,
    input  regIndexType exRt,
    input  regIndexType exDest,
    input  logic exRegWrite,
    input  logic exMemRead,
    input  regIndexType memDest,
    input  logic memRegWrite,
    input  logic memMemRead,
    input  regIndexType wbDest,
    input  logic wbRegWrite,
    output logic stall,
    output forwardSelectType idRsForward,
    output forwardSelectType idRtForward,
    output forwardSelectType exRsForward,
    output forwardSelectType exRtForward
);
    // MEM wins over WB; a load in MEM only has its address there
    function automatic forwardSelectType selectSource(input regIndexType source);
        if (source != '0 && memRegWrite && !memMemRead && memDest == source)
            return fwdMem;
        if (source != '0 && wbRegWrite && wbDest == source)
            return fwdWb;
        return fwdRegister;
    endfunction

    // does a producer's destination feed a source of the ID instruction
    function automatic logic feedsId(input regIndexType dest);
        return dest != '0 && ((idUsesRs && dest == idRs) || (idUsesRt && dest == idRt));
    endfunction

    always_comb begin
        idRsForward = selectSource(idRs);
        idRtForward = selectSource(idRt);
        exRsForward = selectSource(exRs);
        exRtForward = selectSource(exRt);
        stall = (exMemRead && feedsId(exDest)) ||                 // load-use
                (idIsBranch && exRegWrite && feedsId(exDest)) ||  // branch operand still in EX
                (idIsBranch && memMemRead && feedsId(memDest));   // load data not back yet
    end

endmodule

/* logic/executeStage.sv */
`timescale 1ns/1ps

module executeStage import mipsPkg::*; (
    input  logic clock,
    input  logic reset,
    input  aluOpType exAluOp,
    input  logic exAluSrcImm,
    input  logic exRegWrite,
    input  logic exMemRead,
    input  logic exMemWrite,
    input  logic exLink,
    input  regIndexType exDest,
    input  wordType exOperandA,
    input  wordType exOperandB,
    input  wordType exImmediate,
    input  logic [4:0] exShamt,
    input  wordType exPcPlus8,
    input  forwardSelectType rsForward,
    input  forwardSelectType rtForward,
    input  wordType wbWriteData,
    output wordType memAluResult,
    output wordType memStoreData,
    output regIndexType memDest,
    output logic memRegWrite,
    output logic memMemRead,
    output logic memMemWrite
);
    wordType operandA;
    wordType operandB;
    wordType aluB;
    wordType aluResult;

    assign operandA = (rsForward == fwdMem) ? memAluResult :
                      (rsForward == fwdWb) ? wbWriteData : exOperandA;
    assign operandB = (rtForward == fwdMem) ? memAluResult :
                      (rtForward == fwdWb) ? wbWriteData : exOperandB;
    assign aluB = exAluSrcImm ? exImmediate : operandB;

    always_comb begin
        case (exAluOp)
            aluSub: aluResult = operandA - aluB;
            aluAnd: aluResult = operandA & aluB;
            aluOr: aluResult = operandA | aluB;
            aluXor: aluResult = operandA ^ aluB;
            aluNor: aluResult = ~(operandA | aluB);
            aluSlt: aluResult = {31'b0, $signed(operandA) < $signed(aluB)};
            aluSltu: aluResult = {31'b0, operandA < aluB};
            aluSll: aluResult = aluB << exShamt;    // shifts act on rt
            aluSrl: aluResult = aluB >> exShamt;
            aluLui: aluResult = {aluB[15:0], 16'h0000};
            default: aluResult = operandA + aluB;   // ADDU, ADDIU and addresses
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            memRegWrite <= 1'b0;
            memMemRead <= 1'b0;
            memMemWrite <= 1'b0;
        end else begin
            memRegWrite <= exRegWrite;
            memMemRead <= exMemRead;
            memMemWrite <= exMemWrite;
        end
    end

    always_ff @(posedge clock) begin
        memAluResult <= exLink ? exPcPlus8 : aluResult;
        memStoreData <= operandB;    // SW data is the forwarded rt
        memDest <= exDest;
    end

endmodule

/* logic/memoryStage.sv */
`timescale 1ns/1ps

module memoryStage import mipsPkg::*; (
    input  logic clock,
    input  logic reset,
    input  wordType memAluResult,
    input  wordType memStoreData,
    input  regIndexType memDest,
    input  logic memRegWrite,
    input  logic memMemRead,
    input  logic memMemWrite,
    input  wordType dataMemIn,
    output logic [wordAddressWidth-1:0] dataMemAddress,
    output wordType dataMemOut,
    output logic [3:0] dataMemWrite,
    output logic dataMemRead,
    output regIndexType wbDest,
    output logic wbRegWrite,
    output wordType wbWriteData
);
    logic wbMemToReg;
    wordType wbLoadData;
    wordType wbAluResult;

    assign dataMemAddress = memAluResult[31:2];
    assign dataMemOut = memStoreData;
    assign dataMemWrite = {4{memMemWrite}};    // word stores only
    assign dataMemRead = memMemRead;

    always_ff @(posedge clock) begin
        if (reset) wbRegWrite <= 1'b0;
        else wbRegWrite <= memRegWrite;
    end

    always_ff @(posedge clock) begin
        wbDest <= memDest;
        wbMemToReg <= memMemRead;
        wbLoadData <= dataMemIn;    // memory answers in the same cycle
        wbAluResult <= memAluResult;
    end

    assign wbWriteData = wbMemToReg ? wbLoadData : wbAluResult;

endmodule

/* logic/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; #(
    parameter wordType resetVector = '0
) (
    input  logic clock,
    input  logic reset,
    input  wordType instMemIn,
    input  wordType dataMemIn,
    output logic [wordAddressWidth-1:0] instMemAddress,
    output logic instMemRead,
    output logic [wordAddressWidth-1:0] dataMemAddress,
    output wordType dataMemOut,
    output logic [3:0] dataMemWrite,
    output logic dataMemRead
);
    // IF/ID and next-PC
    logic stall;
    logic [1:0] pcSelect;
    wordType jumpTarget;
    wordType branchTarget;
    wordType registerTarget;
    logic [instructionWidth-1:0] ifidInstruction;
    wordType ifidPcPlus4;

    // ID
    regIndexType readIndexA;
    regIndexType readIndexB;
    wordType readDataA;
    wordType readDataB;
    logic idUsesRs;
    logic idUsesRt;
    logic idIsBranch;
    forwardSelectType idRsForward;
    forwardSelectType idRtForward;
    forwardSelectType exRsForward;
    forwardSelectType exRtForward;

    // ID/EX
    aluOpType exAluOp;
    logic exAluSrcImm;
    logic exRegWrite;
    logic exMemRead;
    logic exMemWrite;
    logic exLink;
    regIndexType exDest;
    regIndexType exRs;
    regIndexType exRt;
    wordType exOperandA;
    wordType exOperandB;
    wordType exImmediate;
    logic [4:0] exShamt;
    wordType exPcPlus8;

    // EX/MEM and MEM/WB
    wordType memAluResult;
    wordType memStoreData;
    regIndexType memDest;
    logic memRegWrite;
    logic memMemRead;
    logic memMemWrite;
    regIndexType wbDest;
    logic wbRegWrite;
    wordType wbWriteData;

    fetchStage #(.resetVector(resetVector)) fetch (.*);

    registerFile registers (.*, .writeIndex(wbDest), .writeEnable(wbRegWrite),
        .writeData(wbWriteData));

    decodeStage decode (.*, .instruction(ifidInstruction), .pcPlus4(ifidPcPlus4),
        .rsForward(idRsForward), .rtForward(idRtForward), .usesRs(idUsesRs),
        .usesRt(idUsesRt), .isBranch(idIsBranch));

    hazardUnit hazards (.*, .idRs(readIndexA), .idRt(readIndexB));

    executeStage execute (.*, .rsForward(exRsForward), .rtForward(exRtForward));

    memoryStage memory (.*);

endmodule

/* testbench/mipsCore_assertions.sv */
`timescale 1ns/1ps

module mipsCoreAssertions (
    input logic clock,
    input logic reset,
    input logic [3:0] dataMemWrite,
    input logic dataMemRead
);
    // the stage registers are cleared by the edge that sees reset
    property quietInReset;
        @(posedge clock) reset |=> (dataMemWrite == 4'h0 && !dataMemRead);
    endproperty

    property readOrWrite;
        @(posedge clock) disable iff (reset) !(dataMemRead && dataMemWrite != 4'h0);
    endproperty

    property wholeWordStore;    // only SW exists, so all lanes or none
        @(posedge clock) disable iff (reset) (dataMemWrite == 4'h0 || dataMemWrite == 4'hf);
    endproperty

    assert property (quietInReset) else $error("data memory strobes active during reset");
    assert property (readOrWrite) else $error("read and write strobes active together");
    assert property (wholeWordStore) else $error("partial byte strobes on a store");

endmodule

bind mipsCore mipsCoreAssertions assertions (
    .clock(clock),
    .reset(reset),
    .dataMemWrite(dataMemWrite),
    .dataMemRead(dataMemRead)
);

/* testbench/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb;
    localparam logic [31:0] resetVector = 32'h0000_0000;
    localparam int clockPeriod = 100;
    localparam int resetCycles = 16;

    logic clock;
    logic reset;
    logic [31:0] instMemIn;
    logic [31:0] dataMemIn;
    logic [29:0] instMemAddress;
    logic instMemRead;
    logic [29:0] dataMemAddress;
    logic [31:0] dataMemOut;
    logic [3:0] dataMemWrite;
    logic dataMemRead;

    logic [31:0] instMem [256];
    logic [31:0] dataMem [1024];
    logic [29:0] expectedAddress [$];
    logic [31:0] expectedData [$];
    int programWords = 0;
    int storeIndex = 0;
    int extraStores = 0;
    int checkCount = 0;
    int errorCount = 0;
    bit stimLoaded = 0;

    mipsCore #(.resetVector(resetVector)) DUT (.*);

    // both memories answer in the same cycle
    assign instMemIn = instMem[instMemAddress[7:0]];
    assign dataMemIn = dataMemRead ? dataMem[dataMemAddress[9:0]] : 'x;    // only under the strobe

    always @(posedge clock) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (dataMemWrite[lane])
                dataMem[dataMemAddress[9:0]][8*lane +: 8] <= dataMemOut[8*lane +: 8];
        end
    end

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    task automatic compareValues(input string what, input logic [31:0] actual,
                                 input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // store strobes are stable at the falling edge
    always @(negedge clock) begin
        if (!reset && stimLoaded && dataMemWrite != 4'h0) begin
            if (storeIndex < expectedAddress.size()) begin
                compareValues($sformatf("store %0d address", storeIndex),
                              {2'b00, dataMemAddress}, {2'b00, expectedAddress[storeIndex]});
                compareValues($sformatf("store %0d data", storeIndex),
                              dataMemOut, expectedData[storeIndex]);
                storeIndex++;
            end else begin
                extraStores++;
                $display("unexpected store of %h to word %h after the expected list ended",
                         dataMemOut, dataMemAddress);
            end
        end
    end

    task automatic loadStim();
        int fd;
        int count;
        string line;
        byte kind;
        logic [31:0] address;
        logic [31:0] data;
        fd = $fopen("testbench/coreStim.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("could not open the stimulus file testbench/coreStim.txt");
        end else begin
            while (!$feof(fd)) begin
                count = $fgets(line, fd);
                if (count > 0 && $sscanf(line, "%c %h %h", kind, address, data) == 3) begin
                    if (kind == "P") begin
                        instMem[address[7:0]] = data;
                        programWords++;
                    end else if (kind == "D") begin
                        dataMem[address[9:0]] = data;
                    end else if (kind == "S") begin
                        expectedAddress.push_back(address[29:0]);
                        expectedData.push_back(data);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // limit of 20 cycles per program word on top of reset
    initial begin
        wait (stimLoaded);
        #((20 * programWords + resetCycles) * clockPeriod);
        $display("timeout: %0d of %0d expected stores seen, the program did not finish",
                 storeIndex, expectedAddress.size());
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int errorsBefore;
        reset = 1'b1;
        void'($urandom(32'h458dd6d6));
        for (int i = 0; i < 256; i++) begin
            instMem[i] = 32'h0;    // unused words decode as NOP
        end
        for (int i = 0; i < 1024; i++) begin
            dataMem[i] = $urandom;
        end
        loadStim();
        stimLoaded = 1;

        repeat (resetCycles) @(posedge clock);
        #1 reset = 1'b0;
        errorsBefore = errorCount;
        @(negedge clock);
        compareValues("first fetch address", {instMemAddress, 2'b00}, resetVector);
        compareValues("first fetch read strobe", {31'b0, instMemRead}, 32'h1);
        $display("test reset vector: %s", (errorCount == errorsBefore) ? "ok" : "failed");

        errorsBefore = errorCount;
        wait (storeIndex == expectedAddress.size());
        $display("test store sequence: %s, %0d stores",
                 (errorCount == errorsBefore) ? "ok" : "failed", storeIndex);

        repeat (40) @(posedge clock);    // skipped paths must stay silent
        $display("test no extra stores: %s", (extraStores == 0) ? "ok" : "failed");

        $display("checks %0d, errors %0d, extra stores %0d", checkCount, errorCount, extraStores);
        if (errorCount == 0 && extraStores == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* mipsCore.f */
logic/mipsPkg.sv
logic/fetchStage.sv
logic/registerFile.sv
logic/decodeStage.sv
logic/hazardUnit.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/mipsCore.sv
testbench/mipsCore_assertions.sv
testbench/mipsCoreTb.sv

/* run.sh */
#!/bin/bash
# build the core and testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f mipsCore.f --top-module mipsCoreTb \
    -o simCore || exit 1
./obj_dir/simCore > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || true
grep -q "Simulation PASSED" sim.log && exit 0 || exit 1

/* testbench/coreStim.txt */
# kind wordAddress value: P program word, D initial data word, S expected store
# stores are listed in the order the program makes them
P 00 3C011234
P 01 34215678
P 02 240A0400
P 03 AD410000
P 04 2402FFFB
P 05 24030007
P 06 00432021
P 07 AD440004
P 08 00622823
P 09 0043302A
P 0A 0043382B
P 0B 00204027
P 0C AD450008
P 0D AD46000C
P 0E AD470010
P 0F AD480014
P 10 00014900
P 11 00015A02
P 12 AD490018
P 13 AD4B001C
P 14 00226026
P 15 00226824
P 16 01837025
P 17 AD4C0020
P 18 AD4D0024
P 19 AD4E0028
P 1A 302FFF0F
P 1B 39F000FF
P 1C 2851FFFC
P 1D AD50002C
P 1E AD510030
P 1F 8D520200
P 20 26530001
P 21 AD530034
P 22 AD440204
P 23 8D540204
P 24 AD540038
P 25 24150000
P 26 10430002
P 27 26B50001
P 28 26B50002
P 29 16A00002
P 2A AD55003C
P 2B AD400040
P 2C 0C000032
P 2D 24160055
P 2E AD560044
P 2F AD5F0048
P 30 08000030
P 31 00000000
P 32 24170077
P 33 03E00008
P 34 AD57004C
P 35 AD400050
D 180 CAFEF00D
S 100 12345678
S 101 00000002
S 102 0000000C
S 103 00000001
S 104 00000000
S 105 EDCBA987
S 106 23456780
S 107 00123456
S 108 EDCBA983
S 109 12345678
S 10A EDCBA987
S 10B 000056F7
S 10C 00000001
S 10D CAFEF00E
S 181 00000002
S 10E 00000002
S 10F 00000003
S 113 00000077
S 111 00000055
S 112 000000B8
